//--- ddr_bridge.f
verilog/app_port_pkg.sv
verilog/ram_cmd_pkg.sv
verilog/wr_cmd_queue.sv
verilog/rd_cmd_queue.sv
verilog/app_cmd_arbiter.sv
verilog/rd_return_buffer.sv
verilog/ddr_bridge.sv
tb/app_port_model.sv
tb/tb_ddr_bridge.sv

//--- tb/tb_ddr_bridge.sv
`default_nettype none
`timescale 1ns/100ps

module tb_ddr_bridge
    import app_port_pkg::*;
    import ram_cmd_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int QUEUE_DEPTH  = 4;
    localparam int READ_CREDITS = 4;
    localparam int NUM_ADDRS    = 32;
    localparam int NUM_CMDS     = 400;
    localparam int NUM_RANDOM   = NUM_CMDS - 2 * NUM_ADDRS;

    logic         clk_if = 1'b0;
    logic         resetn;
    ram_cmd_t     ram_cmd;
    logic         ram_cmd_valid;
    logic         ram_cmd_ready;
    ram_rd_resp_t ram_rd_resp;
    logic         ram_rd_resp_valid;
    logic         ram_rd_resp_ready;
    logic         app_cmd_ready;
    logic         app_cmd_en;
    app_cmd_e     app_cmd;
    app_addr_t    app_addr;
    logic         app_wdf_rdy;
    logic         app_wdf_wren;
    app_data_t    app_wdf_data;
    app_mask_t    app_wdf_mask;
    logic         app_wdf_end;
    app_data_t    app_rd_data;
    logic         app_rd_data_valid;

    // Reference memory in program order and responses still owed
    app_data_t    ref_mem [NUM_ADDRS];
    ram_rd_resp_t exp_q [$];
    integer       seed = 32'h5445a222;
    int           errors = 0;
    int           resp_count = 0;
    int           hold_low = 0;
    int           outstanding = 0;
    logic         held = 1'b0;
    ram_rd_resp_t held_resp;

    always #(CLK_PERIOD / 2) clk_if = ~clk_if;

    ddr_bridge #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .READ_CREDITS (READ_CREDITS)
    ) i_ddr_bridge (.*);

    app_port_model #(
        .SEED(32'h5445a222)
    ) i_app_port_model (.*);

    function automatic app_data_t merge_bytes(input app_data_t old, input app_data_t wdata,
                                              input app_mask_t strb);
        app_data_t r;
        r = old;
        for (int b = 0; b < APP_MASK_WIDTH; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic build_cmd(input logic is_write, input int idx, input logic full_strb,
                             output ram_cmd_t c);
        c       = '0;
        c.wr_en = is_write;
        c.rd_en = !is_write;
        c.last  = $random(seed) & 1;
        c.id    = $random(seed) & 8'hff;
        c.addr  = app_addr_t'(idx) << 3;
        if (is_write) begin
            c.wr_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            c.wr_strb = full_strb ? '1 : app_mask_t'($random(seed));
        end
    endtask

    // Advance to the falling edge and pick the response ready
    task automatic next_cycle();
        @(negedge clk_if);
        if (hold_low != 0) begin
            hold_low          = hold_low - 1;
            ram_rd_resp_ready = 1'b0;
        end else begin
            if (($random(seed) & 63) == 0) begin
                hold_low = 24;
            end
            ram_rd_resp_ready = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic send_cmd(input ram_cmd_t c);
        ram_cmd       = c;
        ram_cmd_valid = 1'b1;
        while (ram_cmd_ready !== 1'b1) begin
            next_cycle();
        end
        next_cycle();
        ram_cmd_valid = 1'b0;
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected 0", $time, name, value);
        end
    endtask

    initial begin
        ram_cmd_t c;
        int       idx;
        resetn            = 1'b0;
        ram_cmd           = '0;
        ram_cmd_valid     = 1'b0;
        ram_rd_resp_ready = 1'b0;
        repeat (2) begin
            @(negedge clk_if);
            expect_low("ram_cmd_ready", ram_cmd_ready);
            expect_low("app_cmd_en", app_cmd_en);
            expect_low("app_wdf_wren", app_wdf_wren);
            expect_low("app_wdf_end", app_wdf_end);
            expect_low("ram_rd_resp_valid", ram_rd_resp_valid);
        end
        resetn = 1'b1;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            build_cmd(1'b1, i, 1'b1, c);
            send_cmd(c);
        end
        // Random mix with partial strobes and idle gaps
        for (int i = 0; i < NUM_RANDOM; i++) begin
            idx = $unsigned($random(seed)) % NUM_ADDRS;
            build_cmd($random(seed) & 1, idx, 1'b0, c);
            send_cmd(c);
            if (($random(seed) & 7) == 0) begin
                next_cycle();
            end
        end
        for (int i = 0; i < NUM_ADDRS; i++) begin
            build_cmd(1'b0, i, 1'b0, c);
            send_cmd(c);
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        $display("Checked %0d responses, %0d errors", resp_count, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk_if) begin
        ram_rd_resp_t expected;
        if (resetn) begin
            if (ram_cmd_valid && ram_cmd_ready) begin
                if (ram_cmd.wr_en) begin
                    ref_mem[ram_cmd.addr[7:3]] = merge_bytes(ref_mem[ram_cmd.addr[7:3]],
                                                             ram_cmd.wr_data, ram_cmd.wr_strb);
                end else begin
                    expected.id   = ram_cmd.id;
                    expected.last = ram_cmd.last;
                    expected.data = ref_mem[ram_cmd.addr[7:3]];
                    exp_q.push_back(expected);
                end
            end
            if (app_cmd_en && app_cmd == APP_CMD_WRITE &&
                (app_wdf_wren !== 1'b1 || app_wdf_end !== 1'b1)) begin
                errors++;
                $display("Error at %0t: write command issued without its data beat", $time);
            end
            if (held) begin
                if (ram_rd_resp_valid !== 1'b1) begin
                    errors++;
                    $display("Error at %0t: response valid dropped before acceptance", $time);
                end else if (ram_rd_resp !== held_resp) begin
                    errors++;
                    $display("Mismatch at %0t: ram_rd_resp got %h expected %h", $time,
                             ram_rd_resp, held_resp);
                end
            end
            held      = ram_rd_resp_valid && !ram_rd_resp_ready;
            held_resp = ram_rd_resp;
            if (app_cmd_en && app_cmd_ready && app_cmd == APP_CMD_READ) begin
                outstanding++;
            end
            if (ram_rd_resp_valid && ram_rd_resp_ready) begin
                outstanding--;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: read response with no read outstanding", $time);
                end else begin
                    expected = exp_q.pop_front();
                    resp_count++;
                    if (ram_rd_resp.id !== expected.id) begin
                        errors++;
                        $display("Mismatch at %0t: ram_rd_resp.id got %h expected %h", $time,
                                 ram_rd_resp.id, expected.id);
                    end
                    if (ram_rd_resp.last !== expected.last) begin
                        errors++;
                        $display("Mismatch at %0t: ram_rd_resp.last got %b expected %b", $time,
                                 ram_rd_resp.last, expected.last);
                    end
                    if (ram_rd_resp.data !== expected.data) begin
                        errors++;
                        $display("Mismatch at %0t: ram_rd_resp.data got %h expected %h", $time,
                                 ram_rd_resp.data, expected.data);
                    end
                end
            end
            if (outstanding > READ_CREDITS) begin
                errors++;
                $display("Error at %0t: %0d reads in flight, more than %0d credits", $time,
                         outstanding, READ_CREDITS);
            end
        end
    end

    initial begin
        #(NUM_CMDS * 60 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NUM_CMDS * 60);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/app_port_model.sv
`default_nettype none
`timescale 1ns/100ps

module app_port_model
    import app_port_pkg::*;
#(
    parameter int SEED = 1
) (
    input  wire            clk_if,
    input  wire            resetn,
    input  wire            app_cmd_en,
    input  wire [2:0]      app_cmd,
    input  wire app_addr_t app_addr,
    output logic           app_cmd_ready,
    input  wire            app_wdf_wren,
    input  wire app_data_t app_wdf_data,
    input  wire app_mask_t app_wdf_mask,
    input  wire            app_wdf_end,
    output logic           app_wdf_rdy,
    output app_data_t      app_rd_data,
    output logic           app_rd_data_valid
);

    app_data_t   mem [app_addr_t];
    app_data_t   data_q [$];
    int unsigned due_q [$];
    int unsigned cycle;
    int unsigned due;
    int          seed;
    logic        in_reset;

    // Untouched locations read back a pattern of their address
    function automatic app_data_t stored_word(input app_addr_t a);
        return mem.exists(a) ? mem[a] : {4{32'h5a5a0000 ^ 32'(a)}};
    endfunction

    initial begin
        seed              = SEED;
        cycle             = 0;
        in_reset          = 1'b1;
        app_cmd_ready     = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
    end

    always @(posedge clk_if) begin
        app_data_t word;
        in_reset = !resetn;
        if (!resetn) begin
            data_q.delete();
            due_q.delete();
        end else if (app_cmd_en && app_cmd_ready) begin
            word = stored_word(app_addr);
            if (app_cmd == APP_CMD_READ) begin
                // Kept in order and never before the previous read
                due = cycle + 1 + ($random(seed) & 7);
                if (due_q.size() != 0 && due <= due_q[$]) begin
                    due = due_q[$] + 1;
                end
                data_q.push_back(word);
                due_q.push_back(due);
            end else if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
                for (int b = 0; b < APP_MASK_WIDTH; b++) begin
                    if (!app_wdf_mask[b]) begin
                        word[8*b +: 8] = app_wdf_data[8*b +: 8];
                    end
                end
                mem[app_addr] = word;
            end
        end
        cycle = cycle + 1;
    end

    always @(negedge clk_if) begin
        app_rd_data_valid = 1'b0;
        if (in_reset) begin
            app_cmd_ready = 1'b0;
            app_wdf_rdy   = 1'b0;
        end else begin
            app_cmd_ready = ($random(seed) & 3) != 0;
            app_wdf_rdy   = ($random(seed) & 7) != 0;
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                app_rd_data       = data_q.pop_front();
                app_rd_data_valid = 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/ddr_bridge.sv
`default_nettype none
`timescale 1ns/100ps

module ddr_bridge
    import app_port_pkg::*;
    import ram_cmd_pkg::*;
#(
    parameter int QUEUE_DEPTH  = 4,
    parameter int READ_CREDITS = 4
) (
    input  wire            clk_if,
    input  wire            resetn,
    input  wire ram_cmd_t  ram_cmd,
    input  wire            ram_cmd_valid,
    output logic           ram_cmd_ready,
    output ram_rd_resp_t   ram_rd_resp,
    output logic           ram_rd_resp_valid,
    input  wire            ram_rd_resp_ready,
    input  wire            app_cmd_ready,
    output logic           app_cmd_en,
    output app_cmd_e       app_cmd,
    output app_addr_t      app_addr,
    input  wire            app_wdf_rdy,
    output logic           app_wdf_wren,
    output app_data_t      app_wdf_data,
    output app_mask_t      app_wdf_mask,
    output logic           app_wdf_end,
    input  wire app_data_t app_rd_data,
    input  wire            app_rd_data_valid
);

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    ram_cmd_t      wr_head;
    ram_cmd_t      rd_head;
    logic          wr_space;
    logic          rd_space;
    logic          wr_not_empty;
    logic          rd_not_empty;
    logic          wr_pop;
    logic          rd_pop;
    logic [CW-1:0] wr_count;
    logic [CW-1:0] rd_head_ahead;
    logic          cmd_push;
    logic          rd_issue;
    rd_tag_t       rd_issue_tag;
    logic          credit_return;

    // Each queue keeps only its own command type
    assign ram_cmd_ready = wr_space && rd_space;
    assign cmd_push      = ram_cmd_valid && ram_cmd_ready;

    wr_cmd_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_wr_cmd_queue (
        .clk_if    (clk_if),
        .resetn    (resetn),
        .cmd       (ram_cmd),
        .push      (cmd_push),
        .space     (wr_space),
        .head      (wr_head),
        .not_empty (wr_not_empty),
        .pop       (wr_pop),
        .wr_count  (wr_count)
    );

    rd_cmd_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_rd_cmd_queue (
        .clk_if     (clk_if),
        .resetn     (resetn),
        .cmd        (ram_cmd),
        .push       (cmd_push),
        .wr_count   (wr_count),
        .wr_pop     (wr_pop),
        .space      (rd_space),
        .head       (rd_head),
        .head_ahead (rd_head_ahead),
        .not_empty  (rd_not_empty),
        .pop        (rd_pop)
    );

    app_cmd_arbiter #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .READ_CREDITS (READ_CREDITS)
    ) i_app_cmd_arbiter (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .wr_head       (wr_head),
        .wr_valid      (wr_not_empty),
        .wr_pop        (wr_pop),
        .rd_head       (rd_head),
        .rd_head_ahead (rd_head_ahead),
        .rd_valid      (rd_not_empty),
        .rd_pop        (rd_pop),
        .app_cmd_ready (app_cmd_ready),
        .app_wdf_rdy   (app_wdf_rdy),
        .app_cmd_en    (app_cmd_en),
        .app_cmd       (app_cmd),
        .app_addr      (app_addr),
        .app_wdf_wren  (app_wdf_wren),
        .app_wdf_data  (app_wdf_data),
        .app_wdf_mask  (app_wdf_mask),
        .app_wdf_end   (app_wdf_end),
        .rd_issue      (rd_issue),
        .rd_issue_tag  (rd_issue_tag),
        .credit_return (credit_return)
    );

    rd_return_buffer #(
        .READ_CREDITS(READ_CREDITS)
    ) i_rd_return_buffer (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .rd_issue          (rd_issue),
        .rd_issue_tag      (rd_issue_tag),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .ram_rd_resp       (ram_rd_resp),
        .ram_rd_resp_valid (ram_rd_resp_valid),
        .ram_rd_resp_ready (ram_rd_resp_ready),
        .credit_return     (credit_return)
    );

endmodule

`default_nettype wire

//--- verilog/rd_return_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module rd_return_buffer
    import app_port_pkg::*;
    import ram_cmd_pkg::*;
#(
    parameter int READ_CREDITS = 4
) (
    input  wire            clk_if,
    input  wire            resetn,
    input  wire            rd_issue,
    input  wire rd_tag_t   rd_issue_tag,
    input  wire app_data_t app_rd_data,
    input  wire            app_rd_data_valid,
    output ram_rd_resp_t   ram_rd_resp,
    output logic           ram_rd_resp_valid,
    input  wire            ram_rd_resp_ready,
    output logic           credit_return
);

    localparam int PW = (READ_CREDITS > 1) ? $clog2(READ_CREDITS) : 1;
    localparam int CW = $clog2(READ_CREDITS + 1);

    rd_tag_t        tag_mem  [READ_CREDITS];
    app_data_t      data_mem [READ_CREDITS];
    logic [PW-1:0]  tag_wr_ptr;
    logic [PW-1:0]  data_wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  tag_count;
    logic [CW-1:0]  data_count;
    logic           resp_fire;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(READ_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk_if) begin
        if (rd_issue) begin
            tag_mem[tag_wr_ptr] <= rd_issue_tag;
        end
        if (app_rd_data_valid) begin
            data_mem[data_wr_ptr] <= app_rd_data;
        end
    end

    // Both FIFOs pop together, so one read pointer serves both
    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            tag_wr_ptr  <= '0;
            data_wr_ptr <= '0;
            rd_ptr      <= '0;
            tag_count   <= '0;
            data_count  <= '0;
        end else begin
            if (rd_issue) begin
                tag_wr_ptr <= next_ptr(tag_wr_ptr);
            end
            if (app_rd_data_valid) begin
                data_wr_ptr <= next_ptr(data_wr_ptr);
            end
            if (resp_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            tag_count  <= tag_count + CW'(rd_issue) - CW'(resp_fire);
            data_count <= data_count + CW'(app_rd_data_valid) - CW'(resp_fire);
        end
    end

    assign ram_rd_resp_valid = (tag_count != '0) && (data_count != '0);
    assign resp_fire         = ram_rd_resp_valid && ram_rd_resp_ready;

    // Each transfer frees an entry and hands its credit back
    assign credit_return = resp_fire;

    always_comb begin
        ram_rd_resp.id   = tag_mem[rd_ptr].id;
        ram_rd_resp.last = tag_mem[rd_ptr].last;
        ram_rd_resp.data = data_mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- verilog/app_cmd_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module app_cmd_arbiter
    import app_port_pkg::*;
    import ram_cmd_pkg::*;
#(
    parameter int QUEUE_DEPTH  = 4,
    parameter int READ_CREDITS = 4
) (
    input  wire                             clk_if,
    input  wire                             resetn,
    input  wire ram_cmd_t                   wr_head,
    input  wire                             wr_valid,
    output logic                            wr_pop,
    input  wire ram_cmd_t                   rd_head,
    input  wire [$clog2(QUEUE_DEPTH+1)-1:0] rd_head_ahead,
    input  wire                             rd_valid,
    output logic                            rd_pop,
    input  wire                             app_cmd_ready,
    input  wire                             app_wdf_rdy,
    output logic                            app_cmd_en,
    output app_cmd_e                        app_cmd,
    output app_addr_t                       app_addr,
    output logic                            app_wdf_wren,
    output app_data_t                       app_wdf_data,
    output app_mask_t                       app_wdf_mask,
    output logic                            app_wdf_end,
    output logic                            rd_issue,
    output rd_tag_t                         rd_issue_tag,
    input  wire                             credit_return
);

    localparam int CRW = $clog2(READ_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE_WRITE,
        ISSUE_READ
    } arb_state_e;

    arb_state_e     state;
    arb_state_e     choice;
    arb_state_e     sel;
    logic [CRW-1:0] credits;
    logic           rd_first;
    logic           cmd_accept;

    // Read head goes first once every older write has left
    always_comb begin
        rd_first = rd_valid && (rd_head_ahead == '0);
        if (rd_first) begin
            choice = (credits != '0) ? ISSUE_READ : IDLE;
        end else if (wr_valid) begin
            choice = ISSUE_WRITE;
        end else begin
            choice = IDLE;
        end
        sel = (state == IDLE) ? choice : state;
    end

    always_comb begin
        app_cmd_en   = 1'b0;
        app_cmd      = APP_CMD_WRITE;
        app_addr     = wr_head.addr;
        app_wdf_wren = 1'b0;
        app_wdf_end  = 1'b0;
        wr_pop       = 1'b0;
        rd_pop       = 1'b0;
        case (sel)
            ISSUE_WRITE: begin
                // Command and data go out together
                wr_pop       = app_cmd_ready && app_wdf_rdy;
                app_cmd_en   = wr_pop;
                app_wdf_wren = wr_pop;
                app_wdf_end  = wr_pop;
            end
            ISSUE_READ: begin
                rd_pop     = app_cmd_ready;
                app_cmd_en = app_cmd_ready;
                app_cmd    = APP_CMD_READ;
                app_addr   = rd_head.addr;
            end
            default: ;
        endcase
    end

    assign cmd_accept   = wr_pop || rd_pop;
    assign app_wdf_data = wr_head.wr_data;
    assign app_wdf_mask = ~wr_head.wr_strb;
    assign rd_issue     = rd_pop;
    assign rd_issue_tag = '{id: rd_head.id, last: rd_head.last};

    // Hold a stalled choice until the app port takes it
    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state   <= IDLE;
            credits <= CRW'(READ_CREDITS);
        end else begin
            state   <= (sel != IDLE && !cmd_accept) ? sel : IDLE;
            credits <= credits - CRW'(rd_pop) + CRW'(credit_return);
        end
    end

endmodule

`default_nettype wire

//--- verilog/rd_cmd_queue.sv
`default_nettype none
`timescale 1ns/100ps

module rd_cmd_queue
    import ram_cmd_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                              clk_if,
    input  wire                              resetn,
    input  wire ram_cmd_t                    cmd,
    input  wire                              push,
    input  wire [$clog2(QUEUE_DEPTH+1)-1:0]  wr_count,
    input  wire                              wr_pop,
    output logic                             space,
    output ram_cmd_t                         head,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] head_ahead,
    output logic                             not_empty,
    input  wire                              pop
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    ram_cmd_t       mem   [QUEUE_DEPTH];
    logic [CW-1:0]  ahead [QUEUE_DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic           push_en;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_en    = push && cmd.rd_en;
    assign count_next = count + CW'(push_en) - CW'(pop);

    // Ahead count tracks older writes still queued
    always_ff @(posedge clk_if) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (push_en && (wr_ptr == PW'(i))) begin
                mem[i]   <= cmd;
                ahead[i] <= wr_count - CW'(wr_pop);
            end else if (wr_pop && (ahead[i] != '0)) begin
                ahead[i] <= ahead[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            space  <= 1'b0;
        end else begin
            if (push_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
            space <= (count_next != CW'(QUEUE_DEPTH));
        end
    end

    assign head       = mem[rd_ptr];
    assign head_ahead = ahead[rd_ptr];
    assign not_empty  = (count != '0);

endmodule

`default_nettype wire

//--- verilog/wr_cmd_queue.sv
`default_nettype none
`timescale 1ns/100ps

module wr_cmd_queue
    import ram_cmd_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                              clk_if,
    input  wire                              resetn,
    input  wire ram_cmd_t                    cmd,
    input  wire                              push,
    output logic                             space,
    output ram_cmd_t                         head,
    output logic                             not_empty,
    input  wire                              pop,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] wr_count
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    ram_cmd_t       mem [QUEUE_DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic           push_en;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Only writes land here
    assign push_en    = push && cmd.wr_en;
    assign count_next = count + CW'(push_en) - CW'(pop);

    always_ff @(posedge clk_if) begin
        if (push_en) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            space  <= 1'b0;
        end else begin
            if (push_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
            space <= (count_next != CW'(QUEUE_DEPTH));
        end
    end

    // Fall-through head
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign wr_count  = count;

endmodule

`default_nettype wire

//--- verilog/ram_cmd_pkg.sv
`default_nettype none

// RAM-side command and response formats
package ram_cmd_pkg;

    import app_port_pkg::*;

    localparam int RAM_ID_WIDTH = 8;

    typedef logic [RAM_ID_WIDTH-1:0] ram_id_t;

    // Single-beat command where a set wr_strb bit writes its byte
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        logic      last;
        ram_id_t   id;
        app_addr_t addr;
        app_data_t wr_data;
        app_mask_t wr_strb;
    } ram_cmd_t;

    typedef struct packed {
        ram_id_t   id;
        logic      last;
        app_data_t data;
    } ram_rd_resp_t;

    // Kept per issued read until its data returns
    typedef struct packed {
        ram_id_t id;
        logic    last;
    } rd_tag_t;

endpackage

`default_nettype wire

//--- verilog/app_port_pkg.sv
`default_nettype none

// DDR3 memory-interface application port definitions
package app_port_pkg;

    localparam int APP_DATA_WIDTH = 128;
    localparam int APP_ADDR_WIDTH = 29;
    localparam int APP_MASK_WIDTH = APP_DATA_WIDTH / 8;

    // One app-port data word
    typedef logic [APP_DATA_WIDTH-1:0] app_data_t;

    typedef logic [APP_ADDR_WIDTH-1:0] app_addr_t;

    // One bit per byte lane where a set bit masks the byte on the app port
    typedef logic [APP_MASK_WIDTH-1:0] app_mask_t;

    // Command codes on app_cmd
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

endpackage

`default_nettype wire
